//--- Bender.yml
package:
  name: aes_encipher

sources:
  - files:
      - aes_data_pkg.sv
      - aes_ctrl_pkg.sv
      - aes_sbox_word.sv
      - aes_mixcolumns.sv
      - aes_block_state.sv
      - aes_enc_ctrl.sv
      - aes_encipher_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_aes_encipher.sv

//--- aes_block_state.sv
/*
 * AES state registers, four columns with separate write enables
 * ShiftRows, round-key addition, next-value mux and S-box column select
 */

module aes_block_state
  import aes_data_pkg::*;
  import aes_ctrl_pkg::*;
(
  input  logic      iClk,
  input  logic      rst_n,
  input  update_t   update,
  input  word_idx_t sword_sel,
  input  block_t    block,
  input  block_t    round_key,
  input  word_t     sub_word,
  input  block_t    mixed,
  output word_t     sbox_word,
  output block_t    shifted,
  output block_t    new_block
);

  // Column registers, index 0 is the leftmost column
  word_t                w_reg [NUM_WORDS];
  logic [NUM_WORDS-1:0] w_we;
  block_t               next_block;

  // --------------------------------------------------
  // Current block and ShiftRows
  // --------------------------------------------------
  always_comb begin
    for (int c = 0; c < NUM_WORDS; c++) begin
      new_block[(NUM_WORDS-1-c)*32 +: 32] = w_reg[c];
      // Row r rotates left by r columns
      for (int r = 0; r < 4; r++) begin
        shifted[(NUM_WORDS-1-c)*32 + (3-r)*8 +: 8] =
          w_reg[(c + r) % NUM_WORDS][(3-r)*8 +: 8];
      end
    end
  end

  // Column being substituted this cycle
  assign sbox_word = w_reg[sword_sel];

  // --------------------------------------------------
  // Next value and write enables
  // --------------------------------------------------
  always_comb begin
    next_block = '0;
    w_we       = '0;
    case (update)
      upd_init: begin
        next_block = block ^ round_key;
        w_we       = '1;
      end
      upd_sbox: begin
        // Replicated word, only the selected column takes it
        next_block       = {NUM_WORDS{sub_word}};
        w_we[sword_sel]  = 1'b1;
      end
      upd_main: begin
        next_block = mixed ^ round_key;
        w_we       = '1;
      end
      upd_final: begin
        next_block = shifted ^ round_key;
        w_we       = '1;
      end
      default: begin
        // Hold
      end
    endcase
  end

  // --------------------------------------------------
  // Column registers
  // --------------------------------------------------
  always_ff @(posedge iClk) begin
    if (!rst_n) begin
      for (int c = 0; c < NUM_WORDS; c++) begin
        w_reg[c] <= '0;
      end
    end else begin
      for (int c = 0; c < NUM_WORDS; c++) begin
        if (w_we[c]) begin
          w_reg[c] <= next_block[(NUM_WORDS-1-c)*32 +: 32];
        end
      end
    end
  end

endmodule

//--- aes_ctrl_pkg.sv
/*
 * AES encipher control package
 * FSM state encoding and state-register update kinds
 */

package aes_ctrl_pkg;

  // --------------------------------------------------
  // Encipher FSM states
  // --------------------------------------------------
  typedef enum logic [1:0] {
    idle      = 2'd0,  // Waiting for next
    init      = 2'd1,  // Initial AddRoundKey
    sub_bytes = 2'd2,  // One S-box word per cycle
    mix_round = 2'd3   // ShiftRows, MixColumns, AddRoundKey
  } enc_state_t;

  // --------------------------------------------------
  // What the state registers load in a cycle
  // --------------------------------------------------
  typedef enum logic [2:0] {
    upd_none  = 3'd0,  // Hold
    upd_init  = 3'd1,  // Plaintext xor key
    upd_sbox  = 3'd2,  // One substituted column
    upd_main  = 3'd3,  // MixColumns of ShiftRows, xor key
    upd_final = 3'd4   // ShiftRows xor key, no MixColumns
  } update_t;

endpackage

//--- aes_data_pkg.sv
/*
 * AES datapath package
 * Byte, word and block types, word and round index types, round counts
 */

package aes_data_pkg;

  // --------------------------------------------------
  // Datapath types
  // --------------------------------------------------

  // One byte of the state matrix
  typedef logic [7:0] byte_t;

  // One column of the state, first row in the top byte
  typedef logic [31:0] word_t;

  // Full state, column 0 in the top word
  typedef logic [127:0] block_t;

  // Column index and round number
  typedef logic [1:0] word_idx_t;
  typedef logic [3:0] round_idx_t;

  // --------------------------------------------------
  // Constants
  // --------------------------------------------------
  localparam int NUM_WORDS = 4;

  // Nr for the two supported key lengths
  localparam round_idx_t AES128_ROUNDS = 4'd10;
  localparam round_idx_t AES256_ROUNDS = 4'd14;

endpackage

//--- aes_enc_ctrl.sv
/*
 * AES encipher FSM
 * Round counter, S-box word counter, ready flag and update decode
 */

module aes_enc_ctrl
  import aes_data_pkg::*;
  import aes_ctrl_pkg::*;
(
  input  logic       iClk,
  input  logic       rst_n,
  input  logic       next,
  input  logic       keylen,
  output round_idx_t round,
  output word_idx_t  sword_sel,
  output update_t    update,
  output logic       ready
);

  enc_state_t state_reg;
  round_idx_t round_reg;
  word_idx_t  sword_reg;
  logic       ready_reg;

  round_idx_t num_rounds;
  logic       more_rounds;

  // --------------------------------------------------
  // Round count and output decode
  // --------------------------------------------------

  // Nr from the key length level
  assign num_rounds  = keylen ? AES256_ROUNDS : AES128_ROUNDS;
  // Main round while below Nr, final round at Nr
  assign more_rounds = (round_reg < num_rounds);

  assign round     = round_reg;
  assign sword_sel = sword_reg;
  assign ready     = ready_reg;

  always_comb begin
    case (state_reg)
      init:      update = upd_init;
      sub_bytes: update = upd_sbox;
      mix_round: update = more_rounds ? upd_main : upd_final;
      default:   update = upd_none;
    endcase
  end

  // --------------------------------------------------
  // State and counters
  // --------------------------------------------------
  always_ff @(posedge iClk) begin
    if (!rst_n) begin
      state_reg <= idle;
      round_reg <= '0;
      sword_reg <= '0;
      ready_reg <= 1'b1;
    end else begin
      case (state_reg)
        idle: begin
          // Start only when free, a pulse while busy is dropped
          if (next && ready_reg) begin
            state_reg <= init;
            round_reg <= '0;
            ready_reg <= 1'b0;
          end else begin
            // Raised one cycle after the final round lands
            ready_reg <= 1'b1;
          end
        end
        init: begin
          state_reg <= sub_bytes;
          round_reg <= round_reg + 4'd1;
          sword_reg <= '0;
        end
        sub_bytes: begin
          sword_reg <= sword_reg + 2'd1;
          if (sword_reg == word_idx_t'(NUM_WORDS - 1)) begin
            state_reg <= mix_round;
          end
        end
        mix_round: begin
          sword_reg <= '0;
          if (more_rounds) begin
            state_reg <= sub_bytes;
            round_reg <= round_reg + 4'd1;
          end else begin
            // Round stays at Nr while idle
            state_reg <= idle;
          end
        end
        default: begin
          state_reg <= idle;
        end
      endcase
    end
  end

endmodule

//--- aes_encipher_top.sv
/*
 * AES encipher engine top level
 * Controller, state registers, S-box word and MixColumns
 */

module aes_encipher_top
  import aes_data_pkg::*;
  import aes_ctrl_pkg::*;
(
  input  logic       iClk,
  input  logic       rst_n,
  input  logic       next,
  input  logic       keylen,
  input  block_t     block,
  input  block_t     round_key,
  output round_idx_t round,
  output block_t     new_block,
  output logic       ready
);

  // Controller to datapath
  word_idx_t sword_sel;
  update_t   update;

  // Datapath to S-box and MixColumns and back
  word_t     sbox_word;
  word_t     sub_word;
  block_t    shifted;
  block_t    mixed;

  // --------------------------------------------------
  // Instances
  // --------------------------------------------------
  aes_enc_ctrl aes_enc_ctrl_i (
    .iClk      (iClk),
    .rst_n     (rst_n),
    .next      (next),
    .keylen    (keylen),
    .round     (round),
    .sword_sel (sword_sel),
    .update    (update),
    .ready     (ready)
  );

  aes_block_state aes_block_state_i (
    .iClk      (iClk),
    .rst_n     (rst_n),
    .update    (update),
    .sword_sel (sword_sel),
    .block     (block),
    .round_key (round_key),
    .sub_word  (sub_word),
    .mixed     (mixed),
    .sbox_word (sbox_word),
    .shifted   (shifted),
    .new_block (new_block)
  );

  aes_sbox_word aes_sbox_word_i (
    .word     (sbox_word),
    .sub_word (sub_word)
  );

  aes_mixcolumns aes_mixcolumns_i (
    .shifted (shifted),
    .mixed   (mixed)
  );

endmodule

//--- aes_mixcolumns.sv
/*
 * AES MixColumns over a full 128-bit block
 * GF(2^8) doubling with reduction by 0x1b, four columns in parallel
 */

module aes_mixcolumns
  import aes_data_pkg::*;
(
  input  block_t shifted,
  output block_t mixed
);

  // --------------------------------------------------
  // GF(2^8) helpers
  // --------------------------------------------------

  // Multiply by x, reduce with the AES polynomial on carry out
  function automatic byte_t xtime(input byte_t b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  // One column times the fixed matrix {02 03 01 01}
  function automatic word_t mix_word(input word_t w);
    byte_t b0;
    byte_t b1;
    byte_t b2;
    byte_t b3;
    byte_t m0;
    byte_t m1;
    byte_t m2;
    byte_t m3;
    b0 = w[31:24];
    b1 = w[23:16];
    b2 = w[15:8];
    b3 = w[7:0];
    // 3*b is written as 2*b xor b
    m0 = xtime(b0) ^ xtime(b1) ^ b1 ^ b2 ^ b3;
    m1 = b0 ^ xtime(b1) ^ xtime(b2) ^ b2 ^ b3;
    m2 = b0 ^ b1 ^ xtime(b2) ^ xtime(b3) ^ b3;
    m3 = xtime(b0) ^ b0 ^ b1 ^ b2 ^ xtime(b3);
    return {m0, m1, m2, m3};
  endfunction

  // --------------------------------------------------
  // Column loop
  // --------------------------------------------------

  // Column 0 sits in the top word of the block
  always_comb begin
    for (int c = 0; c < NUM_WORDS; c++) begin
      mixed[(NUM_WORDS-1-c)*32 +: 32] = mix_word(shifted[(NUM_WORDS-1-c)*32 +: 32]);
    end
  end

endmodule

//--- aes_sbox_word.sv
/*
 * Forward AES S-box on one 32-bit word
 * Same table lookup on all four bytes, purely combinational
 */

module aes_sbox_word
  import aes_data_pkg::*;
(
  input  word_t word,
  output word_t sub_word
);

  // --------------------------------------------------
  // Forward S-box table
  // --------------------------------------------------

  // Row n of the table holds entries 16n to 16n+15, entry 0 leftmost
  function automatic byte_t sbox_byte(input byte_t b);
    logic [0:255][7:0] tbl;
    tbl = {
      128'h637c777bf26b6fc5_3001672bfed7ab76,
      128'hca82c97dfa5947f0_add4a2af9ca472c0,
      128'hb7fd9326363ff7cc_34a5e5f171d83115,
      128'h04c723c31896059a_071280e2eb27b275,
      128'h09832c1a1b6e5aa0_523bd6b329e32f84,
      128'h53d100ed20fcb15b_6acbbe394a4c58cf,
      128'hd0efaafb434d3385_45f9027f503c9fa8,
      128'h51a3408f929d38f5_bcb6da2110fff3d2,
      128'hcd0c13ec5f974417_c4a77e3d645d1973,
      128'h60814fdc222a9088_46eeb814de5e0bdb,
      128'he0323a0a4906245c_c2d3ac629195e479,
      128'he7c8376d8dd54ea9_6c56f4ea657aae08,
      128'hba78252e1ca6b4c6_e8dd741f4bbd8b8a,
      128'h703eb5664803f60e_613557b986c11d9e,
      128'he1f8981169d98e94_9b1e87e9ce5528df,
      128'h8ca1890dbfe64268_41992d0fb054bb16
    };
    return tbl[b];
  endfunction

  // --------------------------------------------------
  // Byte-wise substitution
  // --------------------------------------------------

  // Each byte lane goes through its own copy of the table
  always_comb begin
    for (int i = 0; i < NUM_WORDS; i++) begin
      sub_word[8*i +: 8] = sbox_byte(word[8*i +: 8]);
    end
  end

endmodule

//--- tb_aes_encipher.sv
/*
 * AES encipher testbench
 * Stimulus, round-key memory, reference cipher, result checker, watchdog
 */

module tb_aes_encipher
  import aes_data_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_TESTS  = 16;
  localparam int TIMEOUT_NS = NUM_TESTS * 80 * 4 + 400;
  localparam int SEED       = 32'hbb638065;

  logic       iClk;
  logic       rst_n;
  logic       next;
  logic       keylen;
  block_t     block;
  block_t     round_key;
  round_idx_t round;
  block_t     new_block;
  logic       ready;

  // Round keys, looked up by the DUT's round output
  block_t key_mem [15];
  byte_t  ref_sbox [256];

  // Expected results and latencies in start order
  block_t exp_q [$];
  int     lat_q [$];
  int     errors = 0;
  int     checks = 0;
  int     done_count = 0;

  assign round_key = key_mem[round];

  tb_clock_gen tb_clock_gen_i (
    .iClk  (iClk),
    .rst_n (rst_n)
  );

  aes_encipher_top aes_encipher_top_i (
    .iClk      (iClk),
    .rst_n     (rst_n),
    .next      (next),
    .keylen    (keylen),
    .block     (block),
    .round_key (round_key),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Shift-and-add product in GF(2^8)
  function automatic byte_t gf_mul(input byte_t a, input byte_t b);
    byte_t p;
    byte_t x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ x;
      x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
    end
    return p;
  endfunction

  // Inverse as a^254, then the affine map
  function automatic byte_t sbox_calc(input byte_t a);
    byte_t inv;
    inv = 8'h00;
    if (a != 8'h00) begin
      inv = 8'h01;
      for (int i = 0; i < 254; i++) inv = gf_mul(inv, a);
    end
    return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
           {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
  endfunction

  // Textbook cipher, byte i of the block is row i%4 of column i/4
  function automatic block_t aes_reference(input block_t pt, input logic kl);
    byte_t  st [16];
    byte_t  sh [16];
    block_t rk;
    block_t ct;
    int     nr;
    byte_t  a0;
    byte_t  a1;
    byte_t  a2;
    byte_t  a3;
    nr = kl ? 14 : 10;
    rk = key_mem[0];
    for (int i = 0; i < 16; i++) st[i] = pt[127-8*i -: 8] ^ rk[127-8*i -: 8];
    for (int rnd = 1; rnd <= nr; rnd++) begin
      for (int i = 0; i < 16; i++) st[i] = ref_sbox[st[i]];
      // Row r rotates left by r
      for (int c = 0; c < 4; c++) begin
        for (int r = 0; r < 4; r++) sh[4*c+r] = st[4*((c+r)%4)+r];
      end
      for (int c = 0; c < 4; c++) begin
        a0 = sh[4*c];
        a1 = sh[4*c+1];
        a2 = sh[4*c+2];
        a3 = sh[4*c+3];
        if (rnd < nr) begin
          st[4*c]   = gf_mul(a0, 8'h02) ^ gf_mul(a1, 8'h03) ^ a2 ^ a3;
          st[4*c+1] = a0 ^ gf_mul(a1, 8'h02) ^ gf_mul(a2, 8'h03) ^ a3;
          st[4*c+2] = a0 ^ a1 ^ gf_mul(a2, 8'h02) ^ gf_mul(a3, 8'h03);
          st[4*c+3] = gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ gf_mul(a3, 8'h02);
        end else begin
          // Final round skips MixColumns
          for (int r = 0; r < 4; r++) st[4*c+r] = sh[4*c+r];
        end
      end
      rk = key_mem[rnd];
      for (int i = 0; i < 16; i++) st[i] = st[i] ^ rk[127-8*i -: 8];
    end
    for (int i = 0; i < 16; i++) ct[127-8*i -: 8] = st[i];
    return ct;
  endfunction

  // --------------------------------------------------
  // Check and stimulus tasks
  // --------------------------------------------------
  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  // Starts one block at a falling edge with ready high, optional busy pulse
  task automatic run_block(input block_t pt, input logic kl, input int pulse_at);
    keylen = kl;
    block  = pt;
    exp_q.push_back(aes_reference(pt, kl));
    lat_q.push_back(2 + 5 * (kl ? 14 : 10));
    next = 1'b1;
    @(negedge iClk);
    next = 1'b0;
    // Ready drops on the edge that took next
    check_value("ready", ready, 1'b0);
    if (pulse_at > 0) begin
      repeat (pulse_at) @(negedge iClk);
      next = 1'b1;
      @(negedge iClk);
      next = 1'b0;
    end
    while (!ready) @(negedge iClk);
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin : stimulus
    int     seed_ret;
    block_t pt;
    next   = 1'b0;
    keylen = 1'b0;
    block  = '0;
    for (int k = 0; k < 15; k++) key_mem[k] = '0;
    seed_ret = $urandom(SEED);
    for (int i = 0; i < 256; i++) ref_sbox[i] = sbox_calc(i[7:0]);

    // Reset values, before any edge with reset released
    wait (rst_n === 1'b1);
    check_value("ready", ready, 1'b1);
    check_value("new_block", new_block, '0);
    check_value("round", round, '0);
    @(negedge iClk);

    // FIPS-197 appendix B, expanded AES-128 key schedule
    key_mem[0]  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
    key_mem[1]  = 128'ha0fafe1788542cb123a339392a6c7605;
    key_mem[2]  = 128'hf2c295f27a96b9435935807a7359f67f;
    key_mem[3]  = 128'h3d80477d4716fe3e1e237e446d7a883b;
    key_mem[4]  = 128'hef44a541a8525b7fb671253bdb0bad00;
    key_mem[5]  = 128'hd4d1c6f87c839d87caf2b8bc11f915bc;
    key_mem[6]  = 128'h6d88a37a110b3efddbf98641ca0093fd;
    key_mem[7]  = 128'h4e54f70e5f5fc9f384a64fb24ea6dc4f;
    key_mem[8]  = 128'head27321b58dbad2312bf5607f8d292f;
    key_mem[9]  = 128'hac7766f319fadc2128d12941575c006e;
    key_mem[10] = 128'hd014f9a8c9ee2589e13f0cc8b6630ca6;
    pt = 128'h3243f6a8885a308d313198a2e0370734;
    check_value("reference", aes_reference(pt, 1'b0),
                128'h3925841d02dc09fbdc118597196a0b32);
    run_block(pt, 1'b0, 0);

    // Random blocks back to back, AES-256 in the second half
    for (int t = 1; t < NUM_TESTS; t++) begin
      for (int k = 0; k < 15; k++) key_mem[k] = {$urandom, $urandom, $urandom, $urandom};
      pt = {$urandom, $urandom, $urandom, $urandom};
      run_block(pt, t >= NUM_TESTS / 2, (t % 2 == 1) ? 2 + $urandom_range(0, 40) : 0);
    end

    wait (done_count == NUM_TESTS);
    repeat (2) @(negedge iClk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("Some started blocks never produced a result");
    end
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // --------------------------------------------------
  // Result compare, sampled on the falling edge
  // --------------------------------------------------
  initial begin : compare_results
    logic   prev_ready;
    logic   busy;
    int     cycles;
    int     exp_lat;
    block_t exp_block;
    wait (rst_n === 1'b1);
    prev_ready = 1'b1;
    busy       = 1'b0;
    cycles     = 0;
    forever begin
      @(negedge iClk);
      if (prev_ready && !ready) begin
        // Edge that sampled next has just passed
        busy   = 1'b1;
        cycles = 0;
        if (exp_q.size() == 0) begin
          errors++;
          $display("The DUT started without a pending block");
        end else begin
          exp_block = exp_q.pop_front();
          exp_lat   = lat_q.pop_front();
        end
      end else if (busy) begin
        cycles++;
        if (ready) begin
          check_value("latency", cycles, exp_lat);
          check_value("new_block", new_block, exp_block);
          busy = 1'b0;
          done_count++;
        end
      end
      prev_ready = ready;
    end
  end

  // Watchdog, about 80 cycles per block plus margin
  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout: the DUT did not finish all blocks in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset generator
 * 4 ns clock, synchronous active-low reset for two cycles
 */

module tb_clock_gen (
  output logic iClk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  // Free-running clock, 2 ns per phase
  initial begin
    iClk = 1'b0;
    forever #2 iClk = ~iClk;
  end

  // Reset seen by two rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (2) @(posedge iClk);
    @(negedge iClk);
    rst_n = 1'b1;
  end

endmodule

//--- verilog.f
aes_data_pkg.sv
aes_ctrl_pkg.sv
aes_sbox_word.sv
aes_mixcolumns.sv
aes_block_state.sv
aes_enc_ctrl.sv
aes_encipher_top.sv
tb_clock_gen.sv
tb_aes_encipher.sv
